// File: compile.f
+incdir+testbench
common/rv_isa_pkg.sv
common/exu_bus_pkg.sv
exu/exu_alu.sv
exu/exu_branch.sv
exu/exu_lsu.sv
exu/exu_pipe.sv
hdl/uop_credit_fifo.sv
hdl/data_sram.sv
hdl/exu_top.sv
testbench/tb_exu.sv

// File: Makefile
VERILATOR = verilator
VFLAGS = --binary --timing -Wno-fatal
TOP = tb_exu
FILELIST = compile.f
BUILD = obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee /dev/stderr | grep "TEST RESULT: PASS" > /dev/null

clean:
	rm -rf $(BUILD)

// File: testbench/tb_exu_checks.svh
// compare tasks and error counters for the execute-stage testbench, included inside tb_exu
`ifndef TB_EXU_CHECKS_SVH
`define TB_EXU_CHECKS_SVH

// writeback records that differ from the model
int err_wb = 0;
// wrong sender credit balances
int err_credit = 0;
// timeouts and protocol problems
int err_other = 0;

// one writeback record against the model
task automatic check_wb(input string test, input exu_wb_t exp, input exu_wb_t act);
	if (act !== exp) begin
		err_wb++;
		// fields as rd/wen/wdata/redirect_taken/redirect_pc
		$display("FAIL %s: expected %0d/%0b/%h/%0b/%h actual %0d/%0b/%h/%0b/%h", test,
			exp.rd, exp.wen, exp.wdata, exp.redirect_taken, exp.redirect_pc,
			act.rd, act.wen, act.wdata, act.redirect_taken, act.redirect_pc);
	end
endtask

// sender credit balance
task automatic check_credit_count(input string test, input int exp, input int act);
	if (act !== exp) begin
		err_credit++;
		$display("FAIL %s: sender credits expected %0d actual %0d", test, exp, act);
	end
endtask

// anything that is not a value compare
task automatic note_error(input string msg);
	err_other++;
	$display("ERROR %s: %s", cur_test, msg);
endtask

// total of all error kinds
function automatic int error_total();
	return err_wb + err_credit + err_other;
endfunction

`endif

// File: testbench/tb_exu.sv
// directed-test testbench for the execute subsystem, plays decode and writeback and checks records
module tb_exu
	import rv_isa_pkg::*, exu_bus_pkg::*;
();

	// cycles any single wait may take
	localparam int wait_limit = 200;

	logic     clk = 1'b0;
	logic     rst = 1'b1;
	logic     uop_valid = 1'b0;
	exu_uop_t uop = '0;
	logic     uop_credit;
	logic     wb_valid;
	exu_wb_t  wb;
	logic     wb_credit = 1'b0;

	string    cur_test = "init";
	// records predicted in send order
	exu_wb_t  exp_q [$];
	exu_uop_t stim_q [$];
	// byte image of the data memory
	logic [7:0] shadow [dmem_words*4];
	int       credits = uop_q_depth;
	// writebacks seen but not yet returned as credits
	int       owed = 0;
	int       granted = wb_credits_init;
	int       wb_seen = 0;
	logic     hold_credits = 1'b0;
	event     abort_ev;

	`include "tb_exu_checks.svh"

	always #10 clk = ~clk;

	exu_top u_dut (
		.clk        (clk),
		.rst        (rst),
		.uop_valid  (uop_valid),
		.uop        (uop),
		.uop_credit (uop_credit),
		.wb_valid   (wb_valid),
		.wb         (wb),
		.wb_credit  (wb_credit)
	);

	// outputs sampled mid-cycle
	always @(negedge clk) begin
		if (!rst) begin
			if (uop_credit)
				credits++;
			// spurious credits push the balance above the queue depth
			if (credits < 0 || credits > uop_q_depth)
				note_error("sender credit balance outside zero to queue depth");
			if (wb_valid) begin
				wb_seen++;
				owed++;
				if (wb_seen > granted)
					note_error("more writebacks than credits granted");
				if (exp_q.size() == 0)
					note_error("writeback arrived with no expected record");
				else
					check_wb(cur_test, exp_q.pop_front(), wb);
			end
		end
	end

	// receiver, one credit back per cycle unless held
	always @(posedge clk) begin
		if (rst) begin
			wb_credit <= 1'b0;
		end else if (owed > 0 && !hold_credits) begin
			wb_credit <= 1'b1;
			owed--;
			granted++;
		end else begin
			wb_credit <= 1'b0;
		end
	end

	task automatic note_timeout(input string what);
		note_error({"timed out waiting for ", what});
		-> abort_ev;
	endtask

	function automatic logic [xlen-1:0] predict_alu(input alu_op_e op,
			input logic [xlen-1:0] a, input logic [xlen-1:0] b);
		logic [4:0] sh;
		sh = b[4:0];
		case (op)
			alu_add:          return a + b;
			alu_sub:          return a - b;
			alu_and:          return a & b;
			alu_or:           return a | b;
			alu_xor:          return a ^ b;
			alu_sll:          return a << sh;
			alu_srl:          return a >> sh;
			alu_sra:          return 32'($signed(a) >>> sh);
			alu_slt, alu_lt:  return {31'b0, $signed(a) < $signed(b)};
			alu_sltu, alu_ltu: return {31'b0, a < b};
			alu_eq:           return {31'b0, a == b};
			alu_ne:           return {31'b0, a != b};
			alu_ge:           return {31'b0, $signed(a) >= $signed(b)};
			default:          return {31'b0, a >= b};
		endcase
	endfunction

	// expected record, also updates the shadow memory for stores
	function automatic exu_wb_t predict_wb(input exu_uop_t u);
		exu_wb_t w;
		logic [xlen-1:0] res;
		int unsigned a;
		res = predict_alu(u.alu_op, u.src1, u.src2);
		a = res % (dmem_words * 4);
		w.rd = u.rd;
		w.wen = u.rd_wen;
		w.wdata = res;
		w.redirect_taken = 1'b0;
		w.redirect_pc = '0;
		case (u.mem_kind)
			mem_lw:  w.wdata = {shadow[a+3], shadow[a+2], shadow[a+1], shadow[a]};
			mem_lh:  w.wdata = {{16{shadow[a+1][7]}}, shadow[a+1], shadow[a]};
			mem_lhu: w.wdata = {16'h0, shadow[a+1], shadow[a]};
			mem_lb:  w.wdata = {{24{shadow[a][7]}}, shadow[a]};
			mem_lbu: w.wdata = {24'h0, shadow[a]};
			mem_sw: begin
				for (int i = 0; i < 4; i++)
					shadow[a+i] = u.store_data[i*8 +: 8];
			end
			mem_sh: begin
				shadow[a] = u.store_data[7:0];
				shadow[a+1] = u.store_data[15:8];
			end
			mem_sb:  shadow[a] = u.store_data[7:0];
			default: ;
		endcase
		case (u.jump_kind)
			jump_jal: begin
				w.redirect_taken = 1'b1;
				w.redirect_pc = res;
				w.wdata = u.pc + 32'd4;
			end
			jump_jalr: begin
				w.redirect_taken = 1'b1;
				w.redirect_pc = res & ~32'h1;
				w.wdata = u.pc + 32'd4;
			end
			default: begin
				if (u.cond_branch && res[0]) begin
					w.redirect_taken = 1'b1;
					w.redirect_pc = u.cond_target;
				end
			end
		endcase
		return w;
	endfunction

	// plain alu micro-op with a random pc and rd
	function automatic exu_uop_t make_uop(input alu_op_e op, input logic [xlen-1:0] a,
			input logic [xlen-1:0] b);
		exu_uop_t u;
		u = '0;
		u.pc = $urandom & 32'hffff_fffc;
		u.src1 = a;
		u.src2 = b;
		u.rd = 5'($urandom_range(31, 0));
		u.rd_wen = 1'b1;
		u.alu_op = op;
		u.jump_kind = jump_none;
		u.mem_kind = mem_none;
		return u;
	endfunction

	function automatic exu_uop_t make_mem(input mem_kind_e kind, input logic [xlen-1:0] addr,
			input logic [xlen-1:0] data);
		exu_uop_t u;
		// base plus offset through the alu adder
		u = make_uop(alu_add, addr - 32'h40, 32'h40);
		u.mem_kind = kind;
		u.store_data = data;
		u.rd_wen = !(kind inside {mem_sw, mem_sh, mem_sb});
		return u;
	endfunction

	// sends stim_q, one uop per edge while a credit is held
	task automatic send_uops();
		int stall;
		stall = 0;
		while (stim_q.size() != 0) begin
			@(posedge clk);
			if (credits > 0) begin
				uop_valid <= 1'b1;
				uop <= stim_q[0];
				exp_q.push_back(predict_wb(stim_q.pop_front()));
				credits--;
				stall = 0;
			end else begin
				uop_valid <= 1'b0;
				stall++;
				if (stall > wait_limit) begin
					note_timeout("an input credit");
					stim_q.delete();
				end
			end
		end
		@(posedge clk);
		uop_valid <= 1'b0;
	endtask

	// all records back and all credits settled
	task automatic wait_drain();
		int n;
		n = 0;
		while ((exp_q.size() != 0 || owed != 0 || credits != uop_q_depth) && n < wait_limit) begin
			@(negedge clk);
			n++;
		end
		if (exp_q.size() != 0 || owed != 0 || credits != uop_q_depth)
			note_timeout("writebacks to drain");
		repeat (2) @(negedge clk);
	endtask

	task automatic test_reset_idle();
		cur_test = "test_reset_idle";
		repeat (5) begin
			@(negedge clk);
			if (uop_credit !== 1'b0 || wb_valid !== 1'b0)
				note_error("uop_credit or wb_valid active while idle");
		end
		check_credit_count(cur_test, uop_q_depth, credits);
	endtask

	task automatic test_alu_ops();
		exu_uop_t u;
		cur_test = "test_alu_ops";
		for (int op = 0; op < 16; op++) begin
			for (int k = 0; k < 5; k++) begin
				u = make_uop(alu_op_e'(op), $urandom, $urandom);
				case (k)
					0: begin
						u.src1 = 32'h8000_0000;
						u.src2 = 32'h0000_001f;
					end
					1: begin
						u.src1 = 32'hffff_ffff;
						u.src2 = 32'h0000_0001;
					end
					2: begin
						u.src1 = 32'h7fff_ffff;
						u.src2 = 32'h8000_0000;
					end
					3: u.src2 = u.src1;
					default: ;
				endcase
				u.rd_wen = 1'($urandom_range(1, 0));
				stim_q.push_back(u);
			end
		end
		send_uops();
		wait_drain();
	endtask

	task automatic test_branches();
		exu_uop_t u;
		cur_test = "test_branches";
		for (int op = alu_eq; op <= alu_geu; op++) begin
			for (int k = 0; k < 3; k++) begin
				u = make_uop(alu_op_e'(op), $urandom, $urandom);
				// signed and unsigned order disagree on these pairs
				if (k == 0) begin
					u.src2 = u.src1;
				end else begin
					u.src1 = (k == 1) ? 32'hffff_fff0 : 32'h0000_0010;
					u.src2 = (k == 1) ? 32'h0000_0010 : 32'hffff_fff0;
				end
				u.cond_branch = 1'b1;
				u.rd_wen = 1'b0;
				u.rd = '0;
				u.cond_target = u.pc + ($urandom & 32'h0000_0ffc);
				stim_q.push_back(u);
			end
		end
		u = make_uop(alu_add, 32'h0, 32'h0000_0800);
		u.src1 = u.pc;
		u.jump_kind = jump_jal;
		stim_q.push_back(u);
		// odd sums, bit 0 must be dropped
		u = make_uop(alu_add, 32'h0000_1001, 32'h0000_0020);
		u.jump_kind = jump_jalr;
		stim_q.push_back(u);
		u = make_uop(alu_add, 32'h2000_0003, 32'hffff_fffe);
		u.jump_kind = jump_jalr;
		stim_q.push_back(u);
		send_uops();
		wait_drain();
	endtask

	task automatic test_load_store();
		logic [xlen-1:0] base;
		logic [xlen-1:0] d;
		cur_test = "test_load_store";
		for (int w = 0; w < 2; w++) begin
			base = 32'h0000_0300 + 32'(w * 4);
			d = (w == 0) ? 32'h807f_ff01 : $urandom;
			// each store directly followed by a load of the same word
			stim_q.push_back(make_mem(mem_sw, base, d));
			stim_q.push_back(make_mem(mem_lw, base, '0));
			for (int off = 0; off < 4; off += 2) begin
				d = $urandom;
				d[15] = (off == 0);
				stim_q.push_back(make_mem(mem_sh, base + 32'(off), d));
				stim_q.push_back(make_mem(mem_lh, base + 32'(off), '0));
				stim_q.push_back(make_mem(mem_lhu, base + 32'(off), '0));
			end
			for (int off = 0; off < 4; off++) begin
				d = $urandom;
				d[7] = off[0];
				stim_q.push_back(make_mem(mem_sb, base + 32'(off), d));
				stim_q.push_back(make_mem(mem_lb, base + 32'(off), '0));
				stim_q.push_back(make_mem(mem_lbu, base + 32'(off), '0));
			end
			stim_q.push_back(make_mem(mem_lw, base, '0));
		end
		send_uops();
		wait_drain();
	endtask

	task automatic test_back_pressure();
		cur_test = "test_back_pressure";
		hold_credits = 1'b1;
		for (int i = 0; i < 12; i++)
			stim_q.push_back(make_uop(alu_op_e'($urandom_range(15, 0)), $urandom, $urandom));
		fork
			send_uops();
			begin
				repeat (40) @(negedge clk);
				// two fired, queue full, sender out of credits
				check_credit_count(cur_test, 0, credits);
				hold_credits = 1'b0;
			end
		join
		wait_drain();
		check_credit_count(cur_test, uop_q_depth, credits);
	endtask

	initial begin
		void'($urandom(32'h8b9c_d6cd));
		repeat (16) @(posedge clk);
		rst <= 1'b0;
		fork
			begin
				test_reset_idle();
				test_alu_ops();
				test_branches();
				test_load_store();
				test_back_pressure();
			end
			@(abort_ev);
		join_any
		disable fork;
		$display("errors: wb=%0d credit=%0d other=%0d", err_wb, err_credit, err_other);
		if (error_total() == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

// File: hdl/exu_top.sv
// execute subsystem top, joins the input queue, execute pipeline and data memory
module exu_top import rv_isa_pkg::*, exu_bus_pkg::*; (
	input  logic     clk,
	input  logic     rst,
	input  logic     uop_valid,
	input  exu_uop_t uop,
	output logic     uop_credit,
	output logic     wb_valid,
	output exu_wb_t  wb,
	input  logic     wb_credit
);

	logic            head_valid;
	exu_uop_t        head;
	logic            pop;
	dmem_req_t       dmem_req;
	logic [xlen-1:0] dmem_rdata;

	uop_credit_fifo u_uop_q (
		.clk        (clk),
		.rst        (rst),
		.push       (uop_valid),
		.push_uop   (uop),
		.pop        (pop),
		.head_valid (head_valid),
		.head       (head),
		.credit     (uop_credit)
	);

	exu_pipe u_pipe (
		.clk        (clk),
		.rst        (rst),
		.head_valid (head_valid),
		.head       (head),
		.pop        (pop),
		.dmem_req   (dmem_req),
		.dmem_rdata (dmem_rdata),
		.wb_valid   (wb_valid),
		.wb         (wb),
		.wb_credit  (wb_credit)
	);

	data_sram u_dmem (
		.clk      (clk),
		.dmem_req (dmem_req),
		.rdata    (dmem_rdata)
	);

endmodule

// File: hdl/data_sram.sv
// single-port word memory with byte write strobes and a registered read, used as the data memory
module data_sram import rv_isa_pkg::*, exu_bus_pkg::*; (
	input  logic            clk,
	input  dmem_req_t       dmem_req,
	output logic [xlen-1:0] rdata
);

	logic [xlen-1:0] mem [dmem_words];

	// byte lanes written under strobe
	always_ff @(posedge clk) begin
		for (int i = 0; i < xbytes; i++) begin
			if (dmem_req.wen && dmem_req.strb[i])
				mem[dmem_req.word_idx][i*8 +: 8] <= dmem_req.wdata[i*8 +: 8];
		end
	end

	// read every cycle
	// data appears one cycle after the address
	always_ff @(posedge clk) begin
		rdata <= mem[dmem_req.word_idx];
	end

endmodule

// File: hdl/uop_credit_fifo.sv
// input queue for micro-operations, pulses one credit back to the sender per dequeued entry
module uop_credit_fifo import exu_bus_pkg::*; (
	input  logic     clk,
	input  logic     rst,
	input  logic     push,
	input  exu_uop_t push_uop,
	input  logic     pop,
	output logic     head_valid,
	output exu_uop_t head,
	output logic     credit
);

	exu_uop_t               entries [uop_q_depth];
	logic [uop_q_ptr_w-1:0] wr_ptr;
	logic [uop_q_ptr_w-1:0] rd_ptr;
	logic [uop_q_cnt_w-1:0] count;
	logic                   do_push;
	logic                   do_pop;

	// sender never pushes without a credit, full check is a backstop
	assign do_push    = push && (count != uop_q_cnt_w'(uop_q_depth));
	assign do_pop     = pop && head_valid;
	assign head_valid = (count != '0);
	// head visible right after the write edge
	assign head       = entries[rd_ptr];

	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
			credit <= 1'b0;
		end else begin
			if (do_push)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;
			count  <= count + uop_q_cnt_w'(do_push) - uop_q_cnt_w'(do_pop);
			// one credit per freed slot, a cycle after pop
			credit <= do_pop;
		end
	end

	// storage
	always_ff @(posedge clk) begin
		if (do_push)
			entries[wr_ptr] <= push_uop;
	end

endmodule

// File: exu/exu_pipe.sv
// two-stage execute pipeline with writeback credit counting, wraps the ALU, branch unit and LSU
module exu_pipe import rv_isa_pkg::*, exu_bus_pkg::*; (
	input  logic            clk,
	input  logic            rst,
	input  logic            head_valid,
	input  exu_uop_t        head,
	output logic            pop,
	output dmem_req_t       dmem_req,
	input  logic [xlen-1:0] dmem_rdata,
	output logic            wb_valid,
	output exu_wb_t         wb,
	input  logic            wb_credit
);

	// stage register contents
	typedef struct packed {
		logic [reg_addr_w-1:0] rd;
		logic                  rd_wen;
		logic                  is_jump;
		// pc + 4 for jal/jalr
		logic [xlen-1:0]       link;
		logic [xlen-1:0]       alu_result;
		logic                  redirect_taken;
		logic [xlen-1:0]       redirect_pc;
		mem_kind_e             mem_kind;
		logic [byte_off_w-1:0] byte_off;
	} ex_stage_t;

	ex_stage_t              s1_d;
	ex_stage_t              s1_q;
	logic                   s1_valid;
	logic                   s1_is_load;
	logic                   fire;
	logic [wb_credit_w-1:0] wb_cred;
	logic [xlen-1:0]        alu_result;
	logic                   redirect_taken;
	logic [xlen-1:0]        redirect_pc;
	logic [xlen-1:0]        load_data;

	// stage 1 fires only if a credit is left after the one in flight
	assign fire = head_valid && (wb_cred > wb_credit_w'(s1_valid));
	assign pop  = fire;

	exu_alu u_alu (
		.alu_op (head.alu_op),
		.src1   (head.src1),
		.src2   (head.src2),
		.result (alu_result)
	);

	exu_branch u_branch (
		.jump_kind      (head.jump_kind),
		.cond_branch    (head.cond_branch),
		.alu_result     (alu_result),
		.cond_target    (head.cond_target),
		.redirect_taken (redirect_taken),
		.redirect_pc    (redirect_pc)
	);

	// address from the alu sum
	// load side reads back the stage register
	exu_lsu u_lsu (
		.fire       (fire),
		.mem_kind   (head.mem_kind),
		.addr       (alu_result),
		.store_data (head.store_data),
		.dmem_req   (dmem_req),
		.ld_kind    (s1_q.mem_kind),
		.ld_offset  (s1_q.byte_off),
		.dmem_rdata (dmem_rdata),
		.load_data  (load_data)
	);

	always_comb begin
		s1_d.rd             = head.rd;
		s1_d.rd_wen         = head.rd_wen;
		s1_d.is_jump        = (head.jump_kind != jump_none);
		s1_d.link           = head.pc + xlen'(4);
		s1_d.alu_result     = alu_result;
		s1_d.redirect_taken = redirect_taken;
		s1_d.redirect_pc    = redirect_pc;
		s1_d.mem_kind       = head.mem_kind;
		s1_d.byte_off       = alu_result[byte_off_w-1:0];
	end

	// control state
	// credit count moves up on wb_credit and down on wb_valid
	always_ff @(posedge clk) begin
		if (rst) begin
			s1_valid <= 1'b0;
			wb_cred  <= wb_credit_w'(wb_credits_init);
		end else begin
			s1_valid <= fire;
			wb_cred  <= wb_cred + wb_credit_w'(wb_credit) - wb_credit_w'(wb_valid);
		end
	end

	// payload only loads on fire
	always_ff @(posedge clk) begin
		if (fire)
			s1_q <= s1_d;
	end

	// stage 2
	assign s1_is_load = s1_q.mem_kind inside {mem_lw, mem_lh, mem_lhu, mem_lb, mem_lbu};
	assign wb_valid   = s1_valid;

	always_comb begin
		wb.rd             = s1_q.rd;
		wb.wen            = s1_q.rd_wen;
		wb.redirect_taken = s1_q.redirect_taken;
		wb.redirect_pc    = s1_q.redirect_pc;
		// link beats load beats alu
		if (s1_q.is_jump)
			wb.wdata = s1_q.link;
		else if (s1_is_load)
			wb.wdata = load_data;
		else
			wb.wdata = s1_q.alu_result;
	end

endmodule

// File: exu/exu_lsu.sv
// load/store unit, builds strobed data memory requests and extends the returned load word
module exu_lsu import rv_isa_pkg::*, exu_bus_pkg::*; (
	input  logic                  fire,
	input  mem_kind_e             mem_kind,
	input  logic [xlen-1:0]       addr,
	input  logic [xlen-1:0]       store_data,
	output dmem_req_t             dmem_req,
	input  mem_kind_e             ld_kind,
	input  logic [byte_off_w-1:0] ld_offset,
	input  logic [xlen-1:0]       dmem_rdata,
	output logic [xlen-1:0]       load_data
);

	logic [byte_off_w-1:0] addr_off;
	// returned word shifted so the addressed byte is lane 0
	logic [xlen-1:0]       lane_word;

	assign addr_off = addr[byte_off_w-1:0];

	// request side, evaluated in the fire cycle
	always_comb begin
		// word index always driven so a load reads at the fire edge
		dmem_req.word_idx = addr[byte_off_w +: dmem_addr_w];
		dmem_req.wen      = 1'b0;
		dmem_req.strb     = '0;
		dmem_req.wdata    = store_data;
		case (mem_kind)
			mem_sw: begin
				dmem_req.wen  = fire;
				dmem_req.strb = 4'b1111;
			end
			// halfword copied to both halves
			mem_sh: begin
				dmem_req.wen   = fire;
				dmem_req.strb  = 4'b0011 << addr_off;
				dmem_req.wdata = {2{store_data[15:0]}};
			end
			// byte copied to all four lanes
			mem_sb: begin
				dmem_req.wen   = fire;
				dmem_req.strb  = 4'b0001 << addr_off;
				dmem_req.wdata = {4{store_data[7:0]}};
			end
			default: begin
				dmem_req.wen = 1'b0;
			end
		endcase
	end

	// response side, uses the registered kind and offset
	assign lane_word = dmem_rdata >> {ld_offset, 3'b000};

	always_comb begin
		case (ld_kind)
			mem_lh:  load_data = {{16{lane_word[15]}}, lane_word[15:0]};
			mem_lhu: load_data = {16'b0, lane_word[15:0]};
			mem_lb:  load_data = {{24{lane_word[7]}}, lane_word[7:0]};
			mem_lbu: load_data = {24'b0, lane_word[7:0]};
			// lw takes the whole word
			default: load_data = dmem_rdata;
		endcase
	end

endmodule

// File: exu/exu_branch.sv
// resolves conditional branches, jal and jalr into a next-pc redirect from the ALU result
module exu_branch import rv_isa_pkg::*; (
	input  jump_kind_e      jump_kind,
	input  logic            cond_branch,
	input  logic [xlen-1:0] alu_result,
	input  logic [xlen-1:0] cond_target,
	output logic            redirect_taken,
	output logic [xlen-1:0] redirect_pc
);

	// compare result sits in bit 0
	logic cond_taken;

	assign cond_taken = cond_branch & alu_result[0];

	always_comb begin
		redirect_taken = 1'b0;
		redirect_pc    = '0;
		case (jump_kind)
			// pc + j-immediate from the alu
			jump_jal: begin
				redirect_taken = 1'b1;
				redirect_pc    = alu_result;
			end
			// rs1 + imm, lsb forced to zero
			jump_jalr: begin
				redirect_taken = 1'b1;
				redirect_pc    = {alu_result[xlen-1:1], 1'b0};
			end
			default: begin
				redirect_taken = cond_taken;
				if (cond_taken)
					redirect_pc = cond_target;
			end
		endcase
	end

endmodule

// File: exu/exu_alu.sv
// combinational RV32I ALU, also produces the branch compare results used by exu_branch
module exu_alu import rv_isa_pkg::*; (
	input  alu_op_e         alu_op,
	input  logic [xlen-1:0] src1,
	input  logic [xlen-1:0] src2,
	output logic [xlen-1:0] result
);

	// shift amount from the low bits of src2
	logic [$clog2(xlen)-1:0] shamt;
	logic                    eq;
	logic                    lt_s;
	logic                    lt_u;

	assign shamt = src2[$clog2(xlen)-1:0];
	assign eq    = (src1 == src2);
	assign lt_s  = ($signed(src1) < $signed(src2));
	assign lt_u  = (src1 < src2);

	always_comb begin
		result = '0;
		case (alu_op)
			// arithmetic and address generation
			alu_add:  result = src1 + src2;
			alu_sub:  result = src1 - src2;
			// bitwise
			alu_and:  result = src1 & src2;
			alu_or:   result = src1 | src2;
			alu_xor:  result = src1 ^ src2;
			// shifts
			alu_sll:  result = src1 << shamt;
			alu_srl:  result = src1 >> shamt;
			alu_sra:  result = $signed(src1) >>> shamt;
			// set-less-than for slt/slti family
			alu_slt:  result[0] = lt_s;
			alu_sltu: result[0] = lt_u;
			// branch compares
			// beq/bne
			alu_eq:   result[0] = eq;
			alu_ne:   result[0] = ~eq;
			// blt/bge
			alu_lt:   result[0] = lt_s;
			alu_ge:   result[0] = ~lt_s;
			// bltu/bgeu
			alu_ltu:  result[0] = lt_u;
			alu_geu:  result[0] = ~lt_u;
			default:  result = '0;
		endcase
	end

endmodule

// File: common/exu_bus_pkg.sv
// record types passed between decode, execute, data memory and writeback, plus queue sizing
package exu_bus_pkg;

	import rv_isa_pkg::*;

	// input queue depth
	// sender starts with this many credits
	localparam int uop_q_depth = 4;
	localparam int uop_q_ptr_w = 2;
	// occupancy counter, one bit wider than the pointers
	localparam int uop_q_cnt_w = 3;

	// writeback credits held after reset
	localparam int wb_credits_init = 2;
	localparam int wb_credit_w = 2;

	// decoded micro-operation from the decode stage
	typedef struct packed {
		logic [xlen-1:0]       pc;
		// alu operands, operand muxing already done by decode
		logic [xlen-1:0]       src1;
		logic [xlen-1:0]       src2;
		// rs2 value for stores
		logic [xlen-1:0]       store_data;
		// pc + b-immediate
		logic [xlen-1:0]       cond_target;
		logic [reg_addr_w-1:0] rd;
		logic                  rd_wen;
		alu_op_e               alu_op;
		jump_kind_e            jump_kind;
		logic                  cond_branch;
		mem_kind_e             mem_kind;
	} exu_uop_t;

	// one data memory access
	typedef struct packed {
		logic [dmem_addr_w-1:0] word_idx;
		logic                   wen;
		logic [xbytes-1:0]      strb;
		logic [xlen-1:0]        wdata;
	} dmem_req_t;

	// writeback record, one per micro-operation
	typedef struct packed {
		logic [reg_addr_w-1:0] rd;
		logic                  wen;
		logic [xlen-1:0]       wdata;
		logic                  redirect_taken;
		logic [xlen-1:0]       redirect_pc;
	} exu_wb_t;

endpackage

// File: common/rv_isa_pkg.sv
// RV32I widths and operation encodings, imported by every RTL file of the execute stage
package rv_isa_pkg;

	// datapath width, also the address width
	localparam int xlen = 32;
	// byte lanes per data word
	localparam int xbytes = xlen / 8;
	// low address bits that pick a byte inside a word
	localparam int byte_off_w = 2;

	// register file index
	localparam int reg_addr_w = 5;

	// data memory geometry in words
	localparam int dmem_words = 256;
	localparam int dmem_addr_w = 8;

	// alu operations
	// comparison ops leave 0 or 1 in bit 0
	typedef enum logic [3:0] {
		alu_add,
		alu_sub,
		alu_and,
		alu_or,
		alu_xor,
		alu_sll,
		alu_srl,
		alu_sra,
		alu_slt,
		alu_sltu,
		alu_eq,
		alu_ne,
		alu_lt,
		alu_ge,
		alu_ltu,
		alu_geu
	} alu_op_e;

	// unconditional jump flavour
	typedef enum logic [1:0] {
		jump_none,
		jump_jal,
		jump_jalr
	} jump_kind_e;

	// memory access kind, loads first then stores
	typedef enum logic [3:0] {
		mem_none,
		mem_lw,
		mem_lh,
		mem_lhu,
		mem_lb,
		mem_lbu,
		mem_sw,
		mem_sh,
		mem_sb
	} mem_kind_e;

endpackage
